//--- hdl/prefetch_pkg.sv
////////////////////////////////////////
// Shared sizes and word types for the instruction prefetch buffer
// Every block refers to these by scoped names
////////////////////////////////////////

`default_nettype none

package prefetch_pkg;

  // Width of a byte address and of one instruction word
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned WordWidth = 32;

  // Most bus requests that may be granted but not yet answered
  localparam int unsigned NumReqs = 2;

  // FIFO holds one entry per outstanding request plus one for the core
  localparam int unsigned FifoDepth = NumReqs + 1;

  // Address bits below word granularity and the step between words
  localparam int unsigned WordLsb = 2;
  localparam int unsigned WordBytes = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [WordWidth-1:0] word_t;

endpackage

`default_nettype wire

//--- hdl/fetch_addr_gen.sv
////////////////////////////////////////
// Fetch address generation for the prefetch buffer
// Keeps the next word to fetch and the address of a held request
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_addr_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t addr_i,
  input  logic                new_req_i,
  input  logic                held_req_i,
  input  logic                gnt_i,
  output prefetch_pkg::addr_t instr_addr_o
);

  logic                fresh_req;
  prefetch_pkg::addr_t target_addr;
  prefetch_pkg::addr_t fetch_addr_q;
  prefetch_pkg::addr_t stored_addr_q;

  // A request counts as fresh only when nothing is held on the bus
  assign fresh_req = new_req_i & ~held_req_i;

  // Branch targets lose their sub-word bits on entry
  assign target_addr = {addr_i[prefetch_pkg::AddrWidth-1:prefetch_pkg::WordLsb],
                        {prefetch_pkg::WordLsb{1'b0}}};

  // Held request wins so the bus address stays put until granted
  // A branch shows its target at once, otherwise the next fetch address goes out
  assign instr_addr_o = held_req_i ? stored_addr_q :
                        branch_i   ? target_addr   :
                                     fetch_addr_q;

  // Next fetch address loads the target on a branch
  // Each fresh request moves it on by one word, also in the branch cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (branch_i) begin
      fetch_addr_q <= fresh_req ? target_addr + prefetch_pkg::addr_t'(prefetch_pkg::WordBytes)
                                : target_addr;
    end else if (fresh_req) begin
      fetch_addr_q <= fetch_addr_q + prefetch_pkg::addr_t'(prefetch_pkg::WordBytes);
    end
  end

  // Capture what went out on the bus when the memory did not grant it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stored_addr_q <= '0;
    end else if (fresh_req && !gnt_i) begin
      stored_addr_q <= instr_addr_o;
    end
  end

endmodule

`default_nettype wire

//--- hdl/req_tracker.sv
////////////////////////////////////////
// Bus request control for the prefetch buffer
// Issues fetches, holds ungranted ones and tracks outstanding responses
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module req_tracker (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             branch_i,
  input  logic                             gnt_i,
  input  logic                             rvalid_i,
  input  logic [prefetch_pkg::NumReqs-1:0] fifo_busy_i,
  output logic                             new_req_o,
  output logic                             held_req_o,
  output logic                             bus_req_o,
  output logic                             push_valid_o,
  output logic                             busy_o
);

  logic [prefetch_pkg::NumReqs-1:0] outstanding_q;
  logic [prefetch_pkg::NumReqs-1:0] outstanding_n;
  logic [prefetch_pkg::NumReqs-1:0] outstanding_rev;
  logic [prefetch_pkg::NumReqs-1:0] discard_q;
  logic [prefetch_pkg::NumReqs-1:0] discard_n;
  logic [prefetch_pkg::NumReqs-1:0] slot_enter;
  logic                             fifo_ready;
  logic                             granted;
  logic                             held_q;
  logic                             held_discard_q;
  logic                             held_discard_d;

  ////////////////////////////////////////
  // Request issue
  ////////////////////////////////////////

  // Outstanding slots fill from slot 0, so reversing them lets them stack
  // down from the top of the FIFO fill state
  always_comb begin
    for (int i = 0; i < prefetch_pkg::NumReqs; i++) begin
      outstanding_rev[i] = outstanding_q[prefetch_pkg::NumReqs-1-i];
    end
  end

  // There is room while at least one place is neither filled nor promised
  assign fifo_ready = ~&(fifo_busy_i | outstanding_rev);

  // A branch flushes the FIFO, so it may fetch regardless of fill state
  // The last slot must still be free to track the response
  assign new_req_o = req_i & (fifo_ready | branch_i) & ~outstanding_q[prefetch_pkg::NumReqs-1];

  assign bus_req_o  = held_q | new_req_o;
  assign held_req_o = held_q;
  assign granted    = bus_req_o & gnt_i;

  // A held request cannot be withdrawn, so a branch only marks it for discard
  assign held_discard_d = held_q & (branch_i | held_discard_q);

  ////////////////////////////////////////
  // Outstanding queue
  ////////////////////////////////////////

  // A grant takes the lowest free slot, the one just above the last filled one
  assign slot_enter = {prefetch_pkg::NumReqs{granted}} & ~outstanding_q &
                      {outstanding_q[prefetch_pkg::NumReqs-2:0], 1'b1};

  assign outstanding_n = outstanding_q | slot_enter;

  // Discard marks come from a cancelled held request or a branch
  // while the slot is already waiting for its response
  assign discard_n = discard_q |
                     (slot_enter & {prefetch_pkg::NumReqs{held_discard_d}}) |
                     (outstanding_q & {prefetch_pkg::NumReqs{branch_i}});

  // Responses return in grant order, so the oldest sits in slot 0
  assign push_valid_o = rvalid_i & ~discard_q[0];

  assign busy_o = (|outstanding_q) | bus_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q         <= 1'b0;
      held_discard_q <= 1'b0;
      outstanding_q  <= '0;
      discard_q      <= '0;
    end else begin
      held_q         <= bus_req_o & ~gnt_i;
      held_discard_q <= held_discard_d;
      // Each response retires slot 0 and moves the rest down
      if (rvalid_i) begin
        outstanding_q <= {1'b0, outstanding_n[prefetch_pkg::NumReqs-1:1]};
        discard_q     <= {1'b0, discard_n[prefetch_pkg::NumReqs-1:1]};
      end else begin
        outstanding_q <= outstanding_n;
        discard_q     <= discard_n;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_fifo.sv
////////////////////////////////////////
// Compacting word FIFO between the bus and the core
// Entry 0 is the head, an empty FIFO passes its input straight through
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  prefetch_pkg::addr_t              clear_addr_i,
  input  logic                             in_valid_i,
  input  prefetch_pkg::word_t              in_rdata_i,
  input  logic                             in_err_i,
  input  logic                             out_ready_i,
  output logic [prefetch_pkg::NumReqs-1:0] busy_o,
  output logic                             out_valid_o,
  output prefetch_pkg::word_t              out_rdata_o,
  output prefetch_pkg::addr_t              out_addr_o,
  output logic                             out_err_o
);

  logic [prefetch_pkg::FifoDepth-1:0] valid_q;
  logic [prefetch_pkg::FifoDepth-1:0] valid_pushed;
  logic [prefetch_pkg::FifoDepth-1:0] valid_shifted;
  logic [prefetch_pkg::FifoDepth-1:0] lowest_free;
  logic [prefetch_pkg::FifoDepth-1:0] entry_en;
  logic [prefetch_pkg::FifoDepth-1:0] err_q;
  logic [prefetch_pkg::FifoDepth-1:0] err_d;
  prefetch_pkg::word_t [prefetch_pkg::FifoDepth-1:0] rdata_q;
  prefetch_pkg::word_t [prefetch_pkg::FifoDepth-1:0] rdata_d;
  prefetch_pkg::addr_t head_addr_q;
  logic                pop;

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  // Nothing is offered in a branch cycle since the contents belong to the old stream
  assign out_valid_o = ~clear_i & (valid_q[0] | in_valid_i);
  assign out_rdata_o = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign out_err_o   = valid_q[0] ? err_q[0] : in_err_i;
  assign out_addr_o  = head_addr_q;

  assign pop = out_valid_o & out_ready_i;

  // Upper entries tell the request logic how close the FIFO is to full
  assign busy_o = valid_q[prefetch_pkg::FifoDepth-1 -: prefetch_pkg::NumReqs];

  ////////////////////////////////////////
  // Fill state
  ////////////////////////////////////////

  // Entries stay packed from 0, so the first free one sits above the last valid one
  assign lowest_free  = ~valid_q & {valid_q[prefetch_pkg::FifoDepth-2:0], 1'b1};
  assign valid_pushed = valid_q | (lowest_free & {prefetch_pkg::FifoDepth{in_valid_i}});

  // A pop moves every entry one place towards the head
  assign valid_shifted = {1'b0, valid_pushed[prefetch_pkg::FifoDepth-1:1]};

  // Without a pop only the lowest free entry is written
  assign entry_en = pop ? valid_shifted
                        : lowest_free & {prefetch_pkg::FifoDepth{in_valid_i}};

  // Each entry takes its upper neighbour when that holds data, else the input word
  for (genvar i = 0; i < prefetch_pkg::FifoDepth; i++) begin : g_entry
    if (i < prefetch_pkg::FifoDepth - 1) begin : g_lower
      assign rdata_d[i] = valid_q[i+1] ? rdata_q[i+1] : in_rdata_i;
      assign err_d[i]   = valid_q[i+1] ? err_q[i+1] : in_err_i;
    end else begin : g_top
      assign rdata_d[i] = in_rdata_i;
      assign err_d[i]   = in_err_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q[i] <= '0;
        err_q[i]   <= 1'b0;
      end else if (entry_en[i]) begin
        rdata_q[i] <= rdata_d[i];
        err_q[i]   <= err_d[i];
      end
    end
  end

  // Clear drops every entry, including a word pushed in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= pop ? valid_shifted : valid_pushed;
    end
  end

  ////////////////////////////////////////
  // Head address
  ////////////////////////////////////////

  // Address of the oldest word, restarted at the word-aligned target on a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_addr_q <= '0;
    end else if (clear_i) begin
      head_addr_q <= {clear_addr_i[prefetch_pkg::AddrWidth-1:prefetch_pkg::WordLsb],
                      {prefetch_pkg::WordLsb{1'b0}}};
    end else if (pop) begin
      head_addr_q <= head_addr_q + prefetch_pkg::addr_t'(prefetch_pkg::WordBytes);
    end
  end

endmodule

`default_nettype wire

//--- hdl/prefetch_buffer.sv
////////////////////////////////////////
// Instruction prefetch buffer top level
// Joins request control, address generation and the word FIFO
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Core side
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t addr_i,
  input  logic                ready_i,
  output logic                valid_o,
  output prefetch_pkg::word_t rdata_o,
  output prefetch_pkg::addr_t addr_o,
  output logic                err_o,
  output logic                busy_o,
  // Instruction bus
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  prefetch_pkg::word_t instr_rdata_i,
  input  logic                instr_err_i
);

  logic                             new_req;
  logic                             held_req;
  logic                             push_valid;
  logic [prefetch_pkg::NumReqs-1:0] fifo_busy;

  req_tracker u_req_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .fifo_busy_i  (fifo_busy),
    .new_req_o    (new_req),
    .held_req_o   (held_req),
    .bus_req_o    (instr_req_o),
    .push_valid_o (push_valid),
    .busy_o       (busy_o)
  );

  fetch_addr_gen u_fetch_addr_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .branch_i     (branch_i),
    .addr_i       (addr_i),
    .new_req_i    (new_req),
    .held_req_i   (held_req),
    .gnt_i        (instr_gnt_i),
    .instr_addr_o (instr_addr_o)
  );

  // A branch flushes the FIFO and restarts its head address at the target
  fetch_fifo u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (branch_i),
    .clear_addr_i (addr_i),
    .in_valid_i   (push_valid),
    .in_rdata_i   (instr_rdata_i),
    .in_err_i     (instr_err_i),
    .out_ready_i  (ready_i),
    .busy_o       (fifo_busy),
    .out_valid_o  (valid_o),
    .out_rdata_o  (rdata_o),
    .out_addr_o   (addr_o),
    .out_err_o    (err_o)
  );

endmodule

`default_nettype wire

//--- bench/instr_mem_model.sv
////////////////////////////////////////
// Instruction bus responder for the testbench
// Grants and answers with random delays, words follow an address rule
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instr_mem_model (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  prefetch_pkg::addr_t addr_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output prefetch_pkg::word_t rdata_o,
  output logic                err_o
);

  logic [31:0]         lfsr;
  prefetch_pkg::addr_t pend_addr[$];
  int unsigned         pend_due[$];
  int unsigned         cycle;
  logic                gnt_n;
  logic                rvalid_n;
  prefetch_pkg::addr_t resp_addr;

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Memory contents are a fixed function of the word address
  function automatic prefetch_pkg::word_t word_at(input prefetch_pkg::addr_t a);
    return a ^ 32'h5a5a_0f0f;
  endfunction

  // State is updated at the falling edge where the bus is stable,
  // and the next outputs go out just after the rising edge
  initial begin
    lfsr = 32'h0000_3c5d;
    cycle = 0;
    gnt_o = 1'b0;
    rvalid_o = 1'b0;
    rdata_o = '0;
    err_o = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        pend_addr.delete();
        pend_due.delete();
        gnt_n = 1'b0;
        rvalid_n = 1'b0;
      end else begin
        // The oldest pending request was answered this cycle
        if (rvalid_o) begin
          void'(pend_addr.pop_front());
          void'(pend_due.pop_front());
        end
        // A grant answers no earlier than the following cycle
        if (req_i && gnt_o) begin
          pend_addr.push_back(addr_i);
          pend_due.push_back(cycle + 1 + draw_bits(2));
        end
        gnt_n = draw_bits(2) != 0;
        rvalid_n = (pend_addr.size() != 0) && (pend_due[0] <= cycle + 1);
      end
      cycle++;
      resp_addr = rvalid_n ? pend_addr[0] : '0;
      @(posedge clk_i);
      #1;
      gnt_o = gnt_n;
      rvalid_o = rvalid_n;
      rdata_o = rvalid_n ? word_at(resp_addr) : '0;
      // Bus error wherever address bits 7:4 are all ones
      err_o = rvalid_n & (&resp_addr[7:4]);
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_prefetch_buffer.sv
////////////////////////////////////////
// Random testbench for the prefetch buffer
// Drives core requests and branches, checks stream and bus against a model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_buffer;

  localparam int unsigned RunCycles   = 4000;
  localparam int unsigned MinAccepted = 400;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                req;
  logic                branch;
  prefetch_pkg::addr_t addr;
  logic                ready;
  logic                valid;
  prefetch_pkg::word_t rdata;
  prefetch_pkg::addr_t word_addr;
  logic                err;
  logic                busy;
  logic                instr_req;
  prefetch_pkg::addr_t instr_addr;
  logic                instr_gnt;
  logic                instr_rvalid;
  prefetch_pkg::word_t instr_rdata;
  logic                instr_err;

  logic [31:0]         lfsr;
  // Reference model state kept by the monitor
  prefetch_pkg::addr_t exp_addr;
  prefetch_pkg::addr_t granted_q[$];
  int unsigned         accepted;
  int unsigned         grants_since_pop;
  logic                after_branch;
  logic                prev_held;
  prefetch_pkg::addr_t prev_bus_addr;
  logic                prev_stall;
  prefetch_pkg::word_t prev_rdata;
  prefetch_pkg::addr_t prev_addr;
  logic                prev_err;

  prefetch_buffer u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .addr_i         (addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .addr_o         (word_addr),
    .err_o          (err),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .instr_err_i    (instr_err)
  );

  instr_mem_model u_mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata),
    .err_o    (instr_err)
  );

  always #4 clk = ~clk;

  // Galois LFSR stepped once for every bit taken
  function automatic logic [31:0] next_bits(input int unsigned n);
    logic [31:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Word and bus error the memory holds at an address
  function automatic prefetch_pkg::word_t expected_word(input prefetch_pkg::addr_t a);
    return a ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic expected_err(input prefetch_pkg::addr_t a);
    return &a[7:4];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Waits until nothing is requested, outstanding or offered to the core
  task automatic wait_for_idle(input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (busy || valid) begin
      if (n == limit) begin
        abort_run("the buffer did not drain within the timeout");
      end
      n++;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Monitor and reference model
  ////////////////////////////////////////

  // Outputs are sampled at the falling edge, half a cycle after inputs settle
  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("valid_o", 32'(valid), 32'd0);
      check_value("instr_req_o", 32'(instr_req), 32'd0);
      check_value("busy_o", 32'(busy), 32'd0);
      granted_q.delete();
      exp_addr = '0;
      accepted = 0;
      grants_since_pop = 0;
      after_branch = 1'b1;
      prev_held = 1'b0;
      prev_stall = 1'b0;
    end else begin
      // Busy means a request on the bus or a grant still waiting for data
      check_value("busy_o", 32'(busy), 32'(instr_req | (granted_q.size() != 0)));
      // An ungranted request keeps its address, even across a branch
      if (prev_held) begin
        check_value("instr_req_o", 32'(instr_req), 32'd1);
        check_value("instr_addr_o", instr_addr, prev_bus_addr);
      end
      check_value("instr_addr_o[1:0]", 32'(instr_addr[1:0]), 32'd0);
      if (instr_rvalid) begin
        if (granted_q.size() == 0) begin
          abort_run("a bus response arrived with no request outstanding");
        end
        void'(granted_q.pop_front());
      end
      if (instr_req && instr_gnt) begin
        granted_q.push_back(instr_addr);
      end
      if (granted_q.size() > prefetch_pkg::NumReqs) begin
        abort_run("more bus requests are outstanding than the buffer allows");
      end

      // The stream restarts at the aligned target and old words must never show up
      if (branch) begin
        check_value("valid_o", 32'(valid), 32'd0);
        exp_addr = {addr[31:2], 2'b00};
        after_branch = 1'b1;
      end else begin
        // A stalled word holds still until the core takes it
        if (prev_stall) begin
          check_value("valid_o", 32'(valid), 32'd1);
          check_value("rdata_o", rdata, prev_rdata);
          check_value("addr_o", word_addr, prev_addr);
          check_value("err_o", 32'(err), 32'(prev_err));
        end
        if (valid && ready) begin
          check_value("addr_o", word_addr, exp_addr);
          check_value("rdata_o", rdata, expected_word(exp_addr));
          check_value("err_o", 32'(err), 32'(expected_err(exp_addr)));
          exp_addr = exp_addr + 32'd4;
          accepted++;
          grants_since_pop = 0;
          after_branch = 1'b0;
        end
      end

      // Between two transfers the FIFO and the bus together hold FifoDepth words
      if (instr_req && instr_gnt) begin
        grants_since_pop++;
      end
      if (!after_branch && grants_since_pop > prefetch_pkg::FifoDepth) begin
        abort_run("the buffer fetched more words than it has room for");
      end

      prev_held = instr_req & ~instr_gnt;
      prev_bus_addr = instr_addr;
      prev_stall = valid & ~ready & ~branch;
      prev_rdata = rdata;
      prev_addr = word_addr;
      prev_err = err;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int unsigned cycle;
    rst_n = 1'b0;
    req = 1'b0;
    branch = 1'b0;
    addr = '0;
    ready = 1'b0;
    lfsr = 32'he81a;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle after reset with no fetch requested
    repeat (3) begin
      @(negedge clk);
      check_value("valid_o", 32'(valid), 32'd0);
      check_value("instr_req_o", 32'(instr_req), 32'd0);
    end
    @(posedge clk);
    #1;
    req = 1'b1;
    ready = 1'b1;
    branch = 1'b1;
    addr = 32'h0000_1000;

    // Alternates fast and slow core phases every 256 cycles
    for (cycle = 0; cycle < RunCycles; cycle++) begin
      @(posedge clk);
      #1;
      req = next_bits(3) != 0;
      ready = cycle[8] ? (next_bits(2) != 0) : (next_bits(2) == 3);
      branch = next_bits(4) == 0;
      // Low bits stay random to exercise the alignment of targets
      addr = branch ? (32'h0000_1000 | next_bits(10)) : '0;
    end

    @(posedge clk);
    #1;
    req = 1'b0;
    branch = 1'b0;
    addr = '0;
    ready = 1'b1;
    wait_for_idle(200);

    if (accepted < MinAccepted) begin
      abort_run("too few words reached the core during the run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- list.f
hdl/prefetch_pkg.sv
hdl/fetch_addr_gen.sv
hdl/req_tracker.sv
hdl/fetch_fifo.sv
hdl/prefetch_buffer.sv
bench/instr_mem_model.sv
bench/tb_prefetch_buffer.sv

//--- Makefile
# Verilator build and run of the prefetch buffer testbench
SIM := obj_dir/Vtb_prefetch_buffer

.PHONY: all run clean

all: run

$(SIM): list.f $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_prefetch_buffer -f list.f

run: $(SIM)
	./$(SIM) > run.log 2>&1 || true
	cat run.log
	@if grep -q "CHECKS FAILED" run.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" run.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir run.log
